/* common/wb_master_pkg.sv */
/*
 * wishbone master shared definitions
 * bus geometry, the cache request and bus command bundles, and the
 * encodings for the bus sequencer state and the served request source
 */
package wb_master_pkg;

    // ========================================
    // bus geometry
    // ========================================
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int SEL_W       = 4;
    // a line fill is four words and wraps inside address bits 3 to 2
    localparam int BURST_WORDS = 4;

    // ========================================
    // request and bus bundles
    // ========================================
    // instruction side only ever reads, either one word or a whole line
    typedef struct packed {
        logic              req;
        logic              qword;
        logic [ADDR_W-1:0] address;
    } icache_req_t;

    // data side request, byte_en only matters when write is high
    typedef struct packed {
        logic              cached_req;
        logic              uncached_req;
        logic              qword;
        logic              write;
        logic [SEL_W-1:0]  byte_en;
        logic [DATA_W-1:0] wdata;
        logic [ADDR_W-1:0] address;
    } dcache_req_t;

    // one fully formed bus access, offered by the arbiter to the sequencer
    typedef struct packed {
        logic              valid;
        logic              we;
        logic              burst;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } bus_cmd_t;

    // master side of the wishbone bus
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_out_t;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        BURST1   = 3'd1,
        BURST2   = 3'd2,
        BURST3   = 3'd3,
        WAIT_ACK = 3'd4
    } wb_state_e;

    typedef enum logic [1:0] {
        SRC_NONE        = 2'd0,
        SRC_ICACHE      = 2'd1,
        SRC_DC_CACHED   = 2'd2,
        SRC_DC_UNCACHED = 2'd3
    } req_src_e;

endpackage

/* verilog/wb_req_arbiter.sv */
/*
 * cache request arbiter
 * picks data reads, then data writes, then instruction reads, forms the
 * bus command and turns acknowledges into the matching ready pulses
 */
`timescale 1ns/1ps

module wb_req_arbiter
(
    input  logic                       i_clk,
    input  logic                       quick_n_reset,
    input  wb_master_pkg::icache_req_t i_icache,
    input  wb_master_pkg::dcache_req_t i_dcache,
    input  logic                       i_cmd_take,
    input  logic                       i_read_ack,
    input  logic                       i_burst_last,
    output wb_master_pkg::bus_cmd_t    o_cmd,
    output logic                       o_icache_ready,
    output logic                       o_dcache_cached_ready,
    output logic                       o_dcache_uncached_ready
);

    logic                            dc_req;
    logic                            dc_rd_req;
    logic                            dc_wr_req;
    logic                            ic_rd_req;
    logic [wb_master_pkg::SEL_W-1:0] dc_sel;
    logic [1:0]                      dc_adr_lo;
    logic                            wr_take;
    wb_master_pkg::req_src_e         src_next;
    wb_master_pkg::req_src_e         src_r;

    // requesters hold their levels until ready, so plain levels are enough here
    assign dc_req    = i_dcache.cached_req | i_dcache.uncached_req;
    assign dc_rd_req = dc_req & ~i_dcache.write;
    assign dc_wr_req = dc_req & i_dcache.write;
    assign ic_rd_req = i_icache.req;

    // reads always fetch the whole word, writes use the caller's lanes
    assign dc_sel = dc_wr_req ? i_dcache.byte_en : {wb_master_pkg::SEL_W{1'b1}};

    // ========================================
    // low address bits from the lane pattern
    // ========================================
    always_comb
    begin
        case (dc_sel)
            4'b0001: dc_adr_lo = 2'd0;
            4'b0010: dc_adr_lo = 2'd1;
            4'b0100: dc_adr_lo = 2'd2;
            4'b1000: dc_adr_lo = 2'd3;
            // half-word accesses point at the lower lane of the pair
            4'b0011: dc_adr_lo = 2'd0;
            4'b1100: dc_adr_lo = 2'd2;
            // full words and odd patterns stay word aligned
            default: dc_adr_lo = 2'd0;
        endcase
    end

    // ========================================
    // command select
    // ========================================
    always_comb
    begin
        o_cmd       = '0;
        src_next    = wb_master_pkg::SRC_NONE;
        // valid stays up for as long as anybody is asking
        o_cmd.valid = dc_req | ic_rd_req;
        if (dc_rd_req)
        begin
            o_cmd.burst = i_dcache.qword;
            o_cmd.sel   = dc_sel;
            o_cmd.adr   = {i_dcache.address[wb_master_pkg::ADDR_W-1:2], dc_adr_lo};
            // a request flagged both ways is served as cached
            src_next    = i_dcache.cached_req ? wb_master_pkg::SRC_DC_CACHED
                                              : wb_master_pkg::SRC_DC_UNCACHED;
        end
        else if (dc_wr_req)
        begin
            // writes are posted and never wait for a read ack, so no source
            o_cmd.we  = 1'b1;
            o_cmd.sel = dc_sel;
            o_cmd.adr = {i_dcache.address[wb_master_pkg::ADDR_W-1:2], dc_adr_lo};
            o_cmd.dat = i_dcache.wdata;
        end
        else if (ic_rd_req)
        begin
            o_cmd.burst = i_icache.qword;
            o_cmd.sel   = {wb_master_pkg::SEL_W{1'b1}};
            o_cmd.adr   = {i_icache.address[wb_master_pkg::ADDR_W-1:2], 2'b00};
            src_next    = wb_master_pkg::SRC_ICACHE;
        end
    end

    // ========================================
    // served source and ready routing
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            src_r <= wb_master_pkg::SRC_NONE;
        else if (i_cmd_take)
            src_r <= src_next;
        else if (i_burst_last)
            src_r <= wb_master_pkg::SRC_NONE;
    end

    // the write is released in the same cycle the sequencer takes it
    assign wr_take = i_cmd_take & o_cmd.we;

    assign o_icache_ready = i_read_ack & (src_r == wb_master_pkg::SRC_ICACHE);

    assign o_dcache_cached_ready =
        (i_read_ack & (src_r == wb_master_pkg::SRC_DC_CACHED)) |
        (wr_take & i_dcache.cached_req);

    assign o_dcache_uncached_ready =
        (i_read_ack & (src_r == wb_master_pkg::SRC_DC_UNCACHED)) |
        (wr_take & ~i_dcache.cached_req);

    // write releases happen in idle and read acks only mid-cycle, so they never meet
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        $onehot0({o_icache_ready, o_dcache_cached_ready, o_dcache_uncached_ready}));

endmodule

/* bus_seq/wb_bus_seq.sv */
/*
 * wishbone bus cycle sequencer
 * takes one command at a time from idle and runs it as a single
 * transfer or as a four-word wrapping read burst
 */
`timescale 1ns/1ps

module wb_bus_seq
(
    input  logic                    i_clk,
    input  logic                    quick_n_reset,
    input  wb_master_pkg::bus_cmd_t i_cmd,
    input  logic                    i_wb_ack,
    output wb_master_pkg::wb_out_t  o_wb,
    output logic                    o_cmd_take,
    output logic                    o_read_ack,
    output logic                    o_burst_last
);

    // width of the word index that wraps during a line fill
    localparam int BEAT_W = $clog2(wb_master_pkg::BURST_WORDS);

    wb_master_pkg::wb_state_e           state_r;
    logic                               cyc_r;
    logic                               stb_r;
    logic                               we_r;
    logic [wb_master_pkg::SEL_W-1:0]    sel_r;
    logic [wb_master_pkg::ADDR_W-1:0]   adr_r;
    logic [wb_master_pkg::DATA_W-1:0]   dat_r;
    logic                               beat_ack;
    logic                               in_burst;

    // a new command is only accepted with the bus quiet
    assign o_cmd_take = (state_r == wb_master_pkg::IDLE) & i_cmd.valid;

    // an ack only counts while we are actually strobing
    assign beat_ack     = stb_r & i_wb_ack;
    assign o_read_ack   = beat_ack & ~we_r;
    // the final read word always lands in WAIT_ACK, bursts included
    assign o_burst_last = o_read_ack & (state_r == wb_master_pkg::WAIT_ACK);

    assign in_burst = (state_r == wb_master_pkg::BURST1) |
                      (state_r == wb_master_pkg::BURST2) |
                      (state_r == wb_master_pkg::BURST3);

    // ========================================
    // cycle control
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r <= wb_master_pkg::IDLE;
            cyc_r   <= 1'b0;
            stb_r   <= 1'b0;
            we_r    <= 1'b0;
        end
        else
        begin
            case (state_r)
                wb_master_pkg::IDLE:
                begin
                    if (o_cmd_take)
                    begin
                        cyc_r   <= 1'b1;
                        stb_r   <= 1'b1;
                        we_r    <= i_cmd.we;
                        state_r <= i_cmd.burst ? wb_master_pkg::BURST1
                                               : wb_master_pkg::WAIT_ACK;
                    end
                end
                // strobe stays up across the burst, each ack moves one word on
                wb_master_pkg::BURST1:
                begin
                    if (beat_ack)
                        state_r <= wb_master_pkg::BURST2;
                end
                wb_master_pkg::BURST2:
                begin
                    if (beat_ack)
                        state_r <= wb_master_pkg::BURST3;
                end
                wb_master_pkg::BURST3:
                begin
                    if (beat_ack)
                        state_r <= wb_master_pkg::WAIT_ACK;
                end
                wb_master_pkg::WAIT_ACK:
                begin
                    // last word of any access, release the bus
                    if (beat_ack)
                    begin
                        cyc_r   <= 1'b0;
                        stb_r   <= 1'b0;
                        we_r    <= 1'b0;
                        state_r <= wb_master_pkg::IDLE;
                    end
                end
                default:
                    state_r <= wb_master_pkg::IDLE;
            endcase
        end
    end

    // ========================================
    // address and data
    // ========================================
    always_ff @(posedge i_clk)
    begin
        if (o_cmd_take)
        begin
            sel_r <= i_cmd.sel;
            adr_r <= i_cmd.adr;
            dat_r <= i_cmd.dat;
        end
        else if (in_burst && beat_ack)
        begin
            // wrap inside the line, the upper address never moves
            adr_r[2 +: BEAT_W] <= adr_r[2 +: BEAT_W] + 1'b1;
        end
    end

    assign o_wb = '{cyc: cyc_r, stb: stb_r, we: we_r, sel: sel_r, adr: adr_r, dat: dat_r};

    // legal state moves
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wb_master_pkg::IDLE) |=>
            (state_r inside {wb_master_pkg::IDLE, wb_master_pkg::BURST1,
                             wb_master_pkg::WAIT_ACK}));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wb_master_pkg::BURST1) && i_wb_ack |=> (state_r == wb_master_pkg::BURST2));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wb_master_pkg::BURST2) && i_wb_ack |=> (state_r == wb_master_pkg::BURST3));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wb_master_pkg::BURST3) && i_wb_ack |=> (state_r == wb_master_pkg::WAIT_ACK));
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_r == wb_master_pkg::WAIT_ACK) && i_wb_ack |=> (state_r == wb_master_pkg::IDLE));

    // a stalled slave sees the same strobe and address on the next cycle
    assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        stb_r && !i_wb_ack |=> stb_r && $stable(adr_r));

endmodule

/* verilog/wb_master_top.sv */
/*
 * wishbone master top level
 * joins the request arbiter and the bus sequencer between the two
 * cache ports and the shared wishbone bus
 */
`timescale 1ns/1ps

module wb_master_top
(
    input  logic                              i_clk,
    input  logic                              quick_n_reset,
    input  wb_master_pkg::icache_req_t        i_icache,
    input  wb_master_pkg::dcache_req_t        i_dcache,
    input  logic [wb_master_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic                              i_wb_ack,
    output wb_master_pkg::wb_out_t            o_wb,
    output logic [wb_master_pkg::DATA_W-1:0]  o_read_data,
    output logic                              o_icache_ready,
    output logic                              o_dcache_cached_ready,
    output logic                              o_dcache_uncached_ready
);

    // command offered to the sequencer and its handshake back
    wb_master_pkg::bus_cmd_t cmd;
    logic                    cmd_take;
    // read acknowledge and the final word of a read
    logic                    read_ack;
    logic                    burst_last;

    // both caches see the bus data directly, ready says whose it is
    assign o_read_data = i_wb_dat;

    wb_req_arbiter i_wb_req_arbiter
    (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache                (i_icache),
        .i_dcache                (i_dcache),
        .i_cmd_take              (cmd_take),
        .i_read_ack              (read_ack),
        .i_burst_last            (burst_last),
        .o_cmd                   (cmd),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready)
    );

    wb_bus_seq i_wb_bus_seq
    (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_cmd         (cmd),
        .i_wb_ack      (i_wb_ack),
        .o_wb          (o_wb),
        .o_cmd_take    (cmd_take),
        .o_read_ack    (read_ack),
        .o_burst_last  (burst_last)
    );

endmodule

/* bench/wb_mem_slave.sv */
/*
 * wishbone memory slave model
 * 256 words with byte-lane writes and a random acknowledge delay of
 * zero to three wait cycles per word
 */
`timescale 1ns/1ps

module wb_mem_slave
(
    input  logic                             i_clk,
    input  logic                             quick_n_reset,
    input  wb_master_pkg::wb_out_t           i_wb,
    output logic [wb_master_pkg::DATA_W-1:0] o_wb_dat,
    output logic                             o_wb_ack
);

    // unwritten words read back their index mixed with this constant
    localparam logic [31:0] FILL_XOR = 32'ha5c3_9e00;

    logic [31:0] mem [0:255];
    logic [7:0]  idx;
    logic [1:0]  wait_cnt;
    logic [31:0] rnd;
    logic [31:0] wmask;
    integer      seed;

    initial
    begin
        seed = 32'hcdce96cb;
        for (int k = 0; k < 256; k++)
            mem[k] = 32'(k) ^ FILL_XOR;
    end

    // only the word index inside the 1 KiB window is decoded
    assign idx = i_wb.adr[9:2];

    // each select bit opens its own byte of the stored word
    assign wmask = {{8{i_wb.sel[3]}}, {8{i_wb.sel[2]}}, {8{i_wb.sel[1]}}, {8{i_wb.sel[0]}}};

    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            wait_cnt <= 2'd0;
        end
        else if (o_wb_ack)
        begin
            // ack is a single cycle, the master moves on at this edge
            o_wb_ack <= 1'b0;
        end
        else if (i_wb.cyc && i_wb.stb)
        begin
            if (wait_cnt != 2'd0)
                wait_cnt <= wait_cnt - 2'd1;
            else
            begin
                o_wb_ack <= 1'b1;
                o_wb_dat <= mem[idx];
                if (i_wb.we)
                    mem[idx] <= (mem[idx] & ~wmask) | (i_wb.dat & wmask);
                // pick the stall for the next word now
                rnd = $random(seed);
                wait_cnt <= rnd[1:0];
            end
        end
    end

endmodule

/* bench/tb_wb_master.sv */
/*
 * testbench for the wishbone master
 * drives icache and dcache requests against a memory slave and checks
 * every ready pulse and every write cycle against a shadow memory
 */
`timescale 1ns/1ps

module tb_wb_master;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam int          N_WRITES     = 6;
    // bus words moved by all tests together
    localparam int          N_TRANS      = 11 + 2 * N_WRITES;
    localparam int          WATCHDOG_CYC = RESET_CYCLES + N_TRANS * 20;
    localparam logic [31:0] FILL_XOR     = 32'ha5c3_9e00;
    // ready bits in the order {icache, dcache cached, dcache uncached}
    localparam logic [2:0]  RDY_IC       = 3'b100;
    localparam logic [2:0]  RDY_DC       = 3'b010;
    localparam logic [2:0]  RDY_UC       = 3'b001;

    // one ready pulse that a request is owed
    typedef struct packed {
        logic [2:0]  ready;
        logic        is_read;
        logic [31:0] word;
    } pulse_exp_t;

    logic                       i_clk;
    logic                       quick_n_reset;
    wb_master_pkg::icache_req_t icache;
    wb_master_pkg::dcache_req_t dcache;
    wb_master_pkg::wb_out_t     wb;
    logic [31:0]                wb_dat;
    logic                       wb_ack;
    logic [31:0]                read_data;
    logic                       ic_ready;
    logic                       dc_cached_ready;
    logic                       dc_uncached_ready;
    logic [31:0]                shadow [0:255];
    pulse_exp_t                 exp_q[$];
    wb_master_pkg::wb_out_t     wr_q[$];
    pulse_exp_t                 exp_now;
    logic [2:0]                 ready_now;
    int                         mismatch_count;
    int                         other_count;
    integer                     seed;

    wb_master_top i_wb_master_top
    (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache                (icache),
        .i_dcache                (dcache),
        .i_wb_dat                (wb_dat),
        .i_wb_ack                (wb_ack),
        .o_wb                    (wb),
        .o_read_data             (read_data),
        .o_icache_ready          (ic_ready),
        .o_dcache_cached_ready   (dc_cached_ready),
        .o_dcache_uncached_ready (dc_uncached_ready)
    );

    wb_mem_slave i_wb_mem_slave
    (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_wb          (wb),
        .o_wb_dat      (wb_dat),
        .o_wb_ack      (wb_ack)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ========================================
    // reference model
    // ========================================
    // expected word at an address, the shadow mirrors every posted write
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        ref_word = shadow[addr[9:2]];
    endfunction

    // single lanes point at their byte, half words at their lower byte
    function automatic logic [1:0] lane_offset(input logic [3:0] be);
        if (be == 4'b0010)
            lane_offset = 2'd1;
        else if (be == 4'b0100 || be == 4'b1100)
            lane_offset = 2'd2;
        else if (be == 4'b1000)
            lane_offset = 2'd3;
        else
            lane_offset = 2'd0;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ready(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            mismatch_count++;
            $display("mismatch ready {icache,cached,uncached}: got %h expected %h", got, exp);
        end
    endtask

    // with ctrl_only set only cyc, stb and we are compared
    task automatic check_wb(input string name, input wb_master_pkg::wb_out_t got,
                            input wb_master_pkg::wb_out_t exp, input logic ctrl_only);
        if (got.cyc !== exp.cyc || got.stb !== exp.stb || got.we !== exp.we ||
            (!ctrl_only && (got.sel !== exp.sel || got.adr !== exp.adr || got.dat !== exp.dat)))
        begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_read(input logic [2:0] rdy, input logic [31:0] addr);
        exp_q.push_back('{ready: rdy, is_read: 1'b1, word: ref_word(addr)});
    endtask

    // writes in this bench go out uncached, the shadow merges the lanes
    task automatic expect_write(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data);
        exp_q.push_back('{ready: RDY_UC, is_read: 1'b0, word: 32'd0});
        wr_q.push_back('{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: be,
                         adr: {addr[31:2], lane_offset(be)}, dat: data});
        for (int b = 0; b < 4; b++)
            if (be[b])
                shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
    endtask

    // raise both requests, each drops after its own last ready pulse
    task automatic run_access(input wb_master_pkg::icache_req_t ic,
                              input wb_master_pkg::dcache_req_t dc,
                              input int n_ic, input int n_dc);
        int ic_seen;
        int dc_seen;
        int cycles;
        ic_seen = 0;
        dc_seen = 0;
        cycles  = 0;
        icache  = ic;
        dcache  = dc;
        while ((ic_seen < n_ic || dc_seen < n_dc) && cycles < 20 * (n_ic + n_dc))
        begin
            @(posedge i_clk);
            cycles++;
            if (ic_ready)
                ic_seen++;
            if (dc_cached_ready || dc_uncached_ready)
                dc_seen++;
            @(negedge i_clk);
            if (ic_seen >= n_ic)
                icache = '0;
            if (dc_seen >= n_dc)
                dcache = '0;
        end
        if (ic_seen < n_ic || dc_seen < n_dc)
        begin
            other_count++;
            $display("ready pulse missing after %0d cycles: icache %0d of %0d, dcache %0d of %0d",
                     cycles, ic_seen, n_ic, dc_seen, n_dc);
            icache = '0;
            dcache = '0;
            exp_q.delete();
        end
    endtask

    // ========================================
    // response checker
    // ========================================
    always @(posedge i_clk)
    begin
        if (quick_n_reset)
        begin
            ready_now = {ic_ready, dc_cached_ready, dc_uncached_ready};
            if (ready_now != 3'b000)
            begin
                if (exp_q.size() == 0)
                begin
                    other_count++;
                    $display("ready pulse %b arrived with no request outstanding", ready_now);
                end
                else
                begin
                    exp_now = exp_q.pop_front();
                    check_ready(ready_now, exp_now.ready);
                    if (exp_now.is_read)
                        check_word("o_read_data", read_data, exp_now.word);
                end
            end
            // the write is compared on the bus at its acknowledge
            if (wb.cyc && wb.stb && wb.we && wb_ack)
            begin
                if (wr_q.size() == 0)
                begin
                    other_count++;
                    $display("bus write acknowledged that no request asked for");
                end
                else
                    check_wb("o_wb", wb, wr_q.pop_front(), 1'b0);
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial
    begin
        wb_master_pkg::icache_req_t ic;
        wb_master_pkg::dcache_req_t dc;
        logic [31:0]                addr;
        logic [31:0]                data;
        logic [3:0]                 be;
        seed           = 32'hcdce96cb;
        mismatch_count = 0;
        other_count    = 0;
        for (int k = 0; k < 256; k++)
            shadow[k] = 32'(k) ^ FILL_XOR;
        quick_n_reset = 1'b0;
        icache        = '0;
        dcache        = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        quick_n_reset = 1'b1;

        // quiet bus and no ready straight out of reset
        check_wb("o_wb", wb, '0, 1'b1);
        check_ready({ic_ready, dc_cached_ready, dc_uncached_ready}, 3'b000);

        // single instruction read, the byte offset is ignored
        ic = '{req: 1'b1, qword: 1'b0, address: 32'h0000_0106};
        expect_read(RDY_IC, 32'h0000_0104);
        run_access(ic, '0, 1, 0);

        // line fill from word 2 wraps through 3, 0 and 1
        ic = '{req: 1'b1, qword: 1'b1, address: 32'h0000_0208};
        for (int k = 0; k < wb_master_pkg::BURST_WORDS; k++)
            expect_read(RDY_IC, 32'h0000_0200 + 32'(((k + 2) % 4) * 4));
        run_access(ic, '0, 4, 0);

        // posted writes, each read back uncached right behind it
        for (int k = 0; k < N_WRITES; k++)
        begin
            addr = $random(seed);
            addr = addr & 32'h0000_03fc;
            data = $random(seed);
            be   = (data[3:0] == 4'd0) ? 4'b1111 : data[3:0];
            data = $random(seed);
            dc   = '{cached_req: 1'b0, uncached_req: 1'b1, qword: 1'b0, write: 1'b1,
                     byte_en: be, wdata: data, address: addr};
            expect_write(addr, be, data);
            run_access('0, dc, 0, 1);
            dc.write   = 1'b0;
            dc.byte_en = 4'h0;
            dc.wdata   = '0;
            expect_read(RDY_UC, addr);
            run_access('0, dc, 0, 1);
        end

        // cached line fill from word 3, no uncached ready allowed
        dc = '{cached_req: 1'b1, uncached_req: 1'b0, qword: 1'b1, write: 1'b0,
               byte_en: 4'h0, wdata: '0, address: 32'h0000_031c};
        for (int k = 0; k < wb_master_pkg::BURST_WORDS; k++)
            expect_read(RDY_DC, 32'h0000_0310 + 32'(((k + 3) % 4) * 4));
        run_access('0, dc, 0, 4);

        // data and instruction together, data has to finish first
        ic = '{req: 1'b1, qword: 1'b0, address: 32'h0000_0040};
        dc = '{cached_req: 1'b0, uncached_req: 1'b1, qword: 1'b0, write: 1'b0,
               byte_en: 4'h0, wdata: '0, address: 32'h0000_0080};
        expect_read(RDY_UC, 32'h0000_0080);
        expect_read(RDY_IC, 32'h0000_0040);
        run_access(ic, dc, 1, 1);

        repeat (4) @(posedge i_clk);
        if (exp_q.size() != 0 || wr_q.size() != 0)
        begin
            other_count++;
            $display("%0d ready pulses and %0d bus writes never showed up",
                     exp_q.size(), wr_q.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // stops a hung run long after the tests should have ended
    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
        $display("tests failed");
        $finish;
    end

endmodule

/* list.f */
common/wb_master_pkg.sv
verilog/wb_req_arbiter.sv
bus_seq/wb_bus_seq.sv
verilog/wb_master_top.sv
bench/wb_mem_slave.sv
bench/tb_wb_master.sv

/* run.sh */
#!/bin/sh
# build and run the wishbone master testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_tb_wb_master

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_wb_master -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
